// File: src.f
core_pkg.sv
inst_fetch.sv
inst_buffer.sv
decoder_2ri16.sv
decoder_2ri12.sv
id_stage.sv
frontend_top.sv
tb_frontend_top.sv

// File: Bender.yml
package:
  name: frontend_top

sources:
  - core_pkg.sv
  - inst_fetch.sv
  - inst_buffer.sv
  - decoder_2ri16.sv
  - decoder_2ri12.sv
  - id_stage.sv
  - frontend_top.sv
  - target: simulation
    files:
      - tb_frontend_top.sv

// File: tb_frontend_top.sv
module tb_frontend_top;

    localparam int CLK_PERIOD = 40;
    localparam int N_INSTR    = 300;
    localparam int N_TESTS    = 6;

    logic                                  clk;
    logic                                  rst_n_i;
    logic                                  wb_ack_i;
    logic [31:0]                           wb_dat_i;
    logic                                  out_ready_i;
    logic                                  wb_cyc_o;
    logic                                  wb_stb_o;
    logic                                  wb_we_o;
    logic [3:0]                            wb_sel_o;
    logic [31:0]                           wb_adr_o;
    logic                                  out_valid_o;
    logic [31:0]                           out_pc_o;
    logic [31:0]                           out_instr_o;
    logic                                  illegal_o;
    logic [1:0]                            reg_read_valid_o;
    logic [2*core_pkg::REG_ADDR_WIDTH-1:0] reg_read_addr_o;
    logic [31:0]                           imm_o;
    logic                                  reg_write_valid_o;
    logic [core_pkg::REG_ADDR_WIDTH-1:0]   reg_write_addr_o;
    logic [core_pkg::ALU_OP_WIDTH-1:0]     aluop_o;
    logic [core_pkg::ALU_SEL_WIDTH-1:0]    alusel_o;
    core_pkg::special_info_t               special_info_o;

    integer       seed = 32'hedad_e974;
    logic [31:0]  mem [logic [31:0]];
    logic [31:0]  fetched_pc [$];
    logic [31:0]  exp_adr = core_pkg::RESET_PC;
    logic         pending = 1'b0;
    logic         first_req = 1'b1;
    logic         released = 1'b0;
    logic         held = 1'b0;
    logic [159:0] snap;
    int           wait_left;
    int           reset_edges = 0;
    int           n_done = 0;
    int           checks [N_TESTS];
    int           errors [N_TESTS];

    // expected decode of the word at the output
    int                          e_test;
    logic                        e_illegal;
    logic [1:0]                  e_rvalid;
    logic [9:0]                  e_raddr;
    logic [31:0]                 e_imm;
    logic                        e_wvalid;
    logic [4:0]                  e_waddr;
    logic [7:0]                  e_aluop;
    logic [2:0]                  e_alusel;
    core_pkg::special_info_t     e_info;

    frontend_top DUT (
        .clk               (clk),
        .rst_n_i           (rst_n_i),
        .wb_ack_i          (wb_ack_i),
        .wb_dat_i          (wb_dat_i),
        .out_ready_i       (out_ready_i),
        .wb_cyc_o          (wb_cyc_o),
        .wb_stb_o          (wb_stb_o),
        .wb_we_o           (wb_we_o),
        .wb_sel_o          (wb_sel_o),
        .wb_adr_o          (wb_adr_o),
        .out_valid_o       (out_valid_o),
        .out_pc_o          (out_pc_o),
        .out_instr_o       (out_instr_o),
        .illegal_o         (illegal_o),
        .reg_read_valid_o  (reg_read_valid_o),
        .reg_read_addr_o   (reg_read_addr_o),
        .imm_o             (imm_o),
        .reg_write_valid_o (reg_write_valid_o),
        .reg_write_addr_o  (reg_write_addr_o),
        .aluop_o           (aluop_o),
        .alusel_o          (alusel_o),
        .special_info_o    (special_info_o)
    );

    function automatic string test_name(input int id);
        case (id)
            0:       return "reset_state";
            1:       return "fetch_protocol";
            2:       return "branch_decode";
            3:       return "imm_alu_decode";
            4:       return "illegal_words";
            default: return "backpressure_order";
        endcase
    endfunction

    task automatic check_value(input int id, input string what,
                               input logic [159:0] exp, input logic [159:0] act);
        checks[id]++;
        if (exp !== act) begin
            errors[id]++;
            $display("[FAIL] %s %s: expected %0h, actual %0h", test_name(id), what, exp, act);
        end
    endtask

    function automatic logic [7:0] branch_op(input logic [5:0] op);
        case (op)
            core_pkg::EXE_JIRL: return core_pkg::EXE_JIRL_OP;
            core_pkg::EXE_BEQ:  return core_pkg::EXE_BEQ_OP;
            core_pkg::EXE_BNE:  return core_pkg::EXE_BNE_OP;
            core_pkg::EXE_BLT:  return core_pkg::EXE_BLT_OP;
            core_pkg::EXE_BGE:  return core_pkg::EXE_BGE_OP;
            core_pkg::EXE_BLTU: return core_pkg::EXE_BLTU_OP;
            core_pkg::EXE_BGEU: return core_pkg::EXE_BGEU_OP;
            default:            return 8'h00;
        endcase
    endfunction

    function automatic logic [7:0] imm_alu_op(input logic [9:0] op);
        case (op)
            core_pkg::EXE_ADDI_W: return core_pkg::EXE_ADDI_W_OP;
            core_pkg::EXE_SLTI:   return core_pkg::EXE_SLTI_OP;
            core_pkg::EXE_SLTUI:  return core_pkg::EXE_SLTUI_OP;
            core_pkg::EXE_ANDI:   return core_pkg::EXE_ANDI_OP;
            core_pkg::EXE_ORI:    return core_pkg::EXE_ORI_OP;
            core_pkg::EXE_XORI:   return core_pkg::EXE_XORI_OP;
            default:              return 8'h00;
        endcase
    endfunction

    // picks a branch word, an immediate alu word or any word
    function automatic logic [31:0] make_word();
        logic [31:0] w;
        logic [5:0]  ops16 [7];
        logic [9:0]  ops12 [6];
        int          cls;
        ops16 = '{core_pkg::EXE_JIRL, core_pkg::EXE_BEQ, core_pkg::EXE_BNE, core_pkg::EXE_BLT,
                  core_pkg::EXE_BGE, core_pkg::EXE_BLTU, core_pkg::EXE_BGEU};
        ops12 = '{core_pkg::EXE_ADDI_W, core_pkg::EXE_SLTI, core_pkg::EXE_SLTUI,
                  core_pkg::EXE_ANDI, core_pkg::EXE_ORI, core_pkg::EXE_XORI};
        w   = $random(seed);
        cls = $unsigned($random(seed)) % 3;
        if (cls == 0) begin
            w[31:26] = ops16[$unsigned($random(seed)) % 7];
            if (w[31:26] == core_pkg::EXE_JIRL && w[10]) begin
                w[9:5] = 5'd1;
            end
        end else if (cls == 1) begin
            w[31:22] = ops12[$unsigned($random(seed)) % 6];
        end
        return w;
    endfunction

    task automatic predict_decode(input logic [31:0] w);
        logic [7:0] op16;
        logic [7:0] op12;
        op16 = branch_op(w[31:26]);
        op12 = imm_alu_op(w[31:22]);
        {e_illegal, e_rvalid, e_raddr, e_imm, e_wvalid, e_waddr} = '0;
        {e_aluop, e_alusel, e_info} = '0;
        e_test = 4;
        e_illegal = 1'b1;
        if (op16 != 8'h00) begin
            e_test         = 2;
            e_illegal      = 1'b0;
            e_aluop        = op16;
            e_imm          = {{14{w[25]}}, w[25:10], 2'b00};
            e_alusel       = core_pkg::EXE_RES_JUMP;
            e_info.is_branch = 1'b1;
            if (w[31:26] == core_pkg::EXE_JIRL) begin
                e_rvalid = 2'b01;
                e_raddr  = {5'd0, w[9:5]};
                e_wvalid = 1'b1;
                e_waddr  = w[4:0];
                e_info.branch_type = (w[9:5] == 5'd1) ? core_pkg::BRANCH_TYPE_RET
                                                      : core_pkg::BRANCH_TYPE_UNCOND;
            end else begin
                e_rvalid = 2'b11;
                e_raddr  = {w[4:0], w[9:5]};
                e_info.branch_type = core_pkg::BRANCH_TYPE_COND;
            end
        end else if (op12 != 8'h00) begin
            e_test    = 3;
            e_illegal = 1'b0;
            e_aluop   = op12;
            e_rvalid  = 2'b01;
            e_raddr   = {5'd0, w[9:5]};
            e_wvalid  = 1'b1;
            e_waddr   = w[4:0];
            if (w[31:22] == core_pkg::EXE_ANDI || w[31:22] == core_pkg::EXE_ORI
                    || w[31:22] == core_pkg::EXE_XORI) begin
                e_imm    = {20'd0, w[21:10]};
                e_alusel = core_pkg::EXE_RES_LOGIC;
            end else begin
                e_imm    = {{20{w[21]}}, w[21:10]};
                e_alusel = core_pkg::EXE_RES_ARITH;
            end
        end
    endtask

    task automatic check_idle(input string when);
        check_value(0, {when, " cyc"}, 0, wb_cyc_o);
        check_value(0, {when, " stb"}, 0, wb_stb_o);
        check_value(0, {when, " out_valid"}, 0, out_valid_o);
    endtask

    // wishbone slave with 0 to 3 wait cycles and a one-cycle ack
    task automatic serve_bus();
        if (wb_ack_i) begin
            wb_ack_i <= 1'b0;
            pending = 1'b0;
        end else if (wb_cyc_o && wb_stb_o) begin
            if (!pending) begin
                pending   = 1'b1;
                wait_left = $unsigned($random(seed)) % 4;
                check_value(first_req ? 0 : 1, "request address", exp_adr, wb_adr_o);
                check_value(1, "byte select", 4'hf, wb_sel_o);
                first_req = 1'b0;
            end
            if (wait_left == 0) begin
                if (!mem.exists(wb_adr_o)) begin
                    mem[wb_adr_o] = make_word();
                end
                wb_ack_i <= 1'b1;
                wb_dat_i <= mem[wb_adr_o];
                fetched_pc.push_back(wb_adr_o);
                exp_adr = exp_adr + 32'd4;
            end else begin
                wait_left--;
            end
        end
        check_value(1, "stb without cyc", 0, wb_stb_o & ~wb_cyc_o);
        check_value(1, "write enable", 0, wb_we_o);
    endtask

    task automatic check_output();
        logic [159:0] now;
        logic [31:0]  pc;
        now = {out_valid_o, out_pc_o, out_instr_o, illegal_o, reg_read_valid_o, reg_read_addr_o,
               imm_o, reg_write_valid_o, reg_write_addr_o, aluop_o, alusel_o, special_info_o};
        if (held) begin
            check_value(5, "held outputs", snap, now);
        end
        held = out_valid_o && !out_ready_i;
        snap = now;
        if (out_valid_o && out_ready_i) begin
            if (fetched_pc.size() == 0) begin
                errors[5]++;
                $display("error: decoded word delivered with no fetched word outstanding");
            end else begin
                pc = fetched_pc.pop_front();
                check_value(5, "out_pc", pc, out_pc_o);
                check_value(5, "out_instr", mem[pc], out_instr_o);
                predict_decode(mem[pc]);
                check_value(e_test, "illegal", e_illegal, illegal_o);
                check_value(e_test, "read valid", e_rvalid, reg_read_valid_o);
                check_value(e_test, "read addr", e_raddr, reg_read_addr_o);
                check_value(e_test, "imm", e_imm, imm_o);
                check_value(e_test, "write valid", e_wvalid, reg_write_valid_o);
                check_value(e_test, "write addr", e_waddr, reg_write_addr_o);
                check_value(e_test, "aluop", e_aluop, aluop_o);
                check_value(e_test, "alusel", e_alusel, alusel_o);
                check_value(e_test, "special info", e_info, special_info_o);
            end
            n_done++;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst_n_i     = 1'b0;
        wb_ack_i    = 1'b0;
        wb_dat_i    = '0;
        out_ready_i = 1'b0;
        repeat (8) @(posedge clk);
        rst_n_i <= 1'b1;
    end

    always @(posedge clk) begin
        if (!rst_n_i) begin
            // outputs are known from the first reset edge on
            if (reset_edges > 0) begin
                check_idle("during reset");
            end
            reset_edges++;
        end else begin
            if (!released) begin
                check_idle("after reset");
                released = 1'b1;
            end
            serve_bus();
            check_output();
            out_ready_i <= $random(seed) & 1;
        end
    end

    initial begin
        int passed;
        int failed;
        passed = 0;
        failed = 0;
        wait (n_done == N_INSTR);
        for (int i = 0; i < N_TESTS; i++) begin
            if (errors[i] == 0) begin
                passed++;
                $display("test %s: passed, %0d checks", test_name(i), checks[i]);
            end else begin
                failed++;
                $display("test %s: %0d of %0d checks wrong", test_name(i), errors[i], checks[i]);
            end
        end
        $display("tests passed: %0d, tests failed: %0d", passed, failed);
        if (failed == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // eight cycles per instruction is far above the worst fetch and stall rate
    initial begin
        #(N_INSTR * 8 * CLK_PERIOD);
        $display("timeout: only %0d of %0d instructions were decoded", n_done, N_INSTR);
        $display("Regression failed");
        $finish;
    end

endmodule

// File: frontend_top.sv
module frontend_top (
    input  logic                                  clk,
    input  logic                                  rst_n_i,
    input  logic                                  wb_ack_i,
    input  logic [core_pkg::DATA_WIDTH-1:0]       wb_dat_i,
    input  logic                                  out_ready_i,
    output logic                                  wb_cyc_o,
    output logic                                  wb_stb_o,
    output logic                                  wb_we_o,
    output logic [3:0]                            wb_sel_o,
    output logic [core_pkg::DATA_WIDTH-1:0]       wb_adr_o,
    output logic                                  out_valid_o,
    output logic [core_pkg::DATA_WIDTH-1:0]       out_pc_o,
    output logic [core_pkg::INSTR_WIDTH-1:0]      out_instr_o,
    output logic                                  illegal_o,
    output logic [1:0]                            reg_read_valid_o,
    output logic [2*core_pkg::REG_ADDR_WIDTH-1:0] reg_read_addr_o,
    output logic [core_pkg::DATA_WIDTH-1:0]       imm_o,
    output logic                                  reg_write_valid_o,
    output logic [core_pkg::REG_ADDR_WIDTH-1:0]   reg_write_addr_o,
    output logic [core_pkg::ALU_OP_WIDTH-1:0]     aluop_o,
    output logic [core_pkg::ALU_SEL_WIDTH-1:0]    alusel_o,
    output core_pkg::special_info_t               special_info_o
);

    // fetch to queue
    logic                             push;
    logic [core_pkg::DATA_WIDTH-1:0]  push_pc;
    logic [core_pkg::INSTR_WIDTH-1:0] push_instr;
    logic                             buf_full;

    // queue to decode
    logic [core_pkg::DATA_WIDTH-1:0]  head_pc;
    logic [core_pkg::INSTR_WIDTH-1:0] head_instr;
    logic                             buf_empty;
    logic                             pop;

    inst_fetch u_fetch (
        .*,
        .buffer_full_i (buf_full),
        .push_o        (push),
        .push_pc_o     (push_pc),
        .push_instr_o  (push_instr)
    );

    inst_buffer u_ibuf (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .push_i       (push),
        .push_pc_i    (push_pc),
        .push_instr_i (push_instr),
        .pop_i        (pop),
        .head_pc_o    (head_pc),
        .head_instr_o (head_instr),
        .full_o       (buf_full),
        .empty_o      (buf_empty)
    );

    // decoded outputs keep their names up to the top ports
    id_stage u_id (
        .*,
        .head_pc_i    (head_pc),
        .head_instr_i (head_instr),
        .empty_i      (buf_empty),
        .pop_o        (pop)
    );

endmodule

// File: id_stage.sv
module id_stage (
    input  logic                                  clk,
    input  logic                                  rst_n_i,
    input  logic [core_pkg::DATA_WIDTH-1:0]       head_pc_i,
    input  logic [core_pkg::INSTR_WIDTH-1:0]      head_instr_i,
    input  logic                                  empty_i,
    input  logic                                  out_ready_i,
    output logic                                  pop_o,
    output logic                                  out_valid_o,
    output logic [core_pkg::DATA_WIDTH-1:0]       out_pc_o,
    output logic [core_pkg::INSTR_WIDTH-1:0]      out_instr_o,
    output logic                                  illegal_o,
    output logic [1:0]                            reg_read_valid_o,
    output logic [2*core_pkg::REG_ADDR_WIDTH-1:0] reg_read_addr_o,
    output logic [core_pkg::DATA_WIDTH-1:0]       imm_o,
    output logic                                  reg_write_valid_o,
    output logic [core_pkg::REG_ADDR_WIDTH-1:0]   reg_write_addr_o,
    output logic [core_pkg::ALU_OP_WIDTH-1:0]     aluop_o,
    output logic [core_pkg::ALU_SEL_WIDTH-1:0]    alusel_o,
    output core_pkg::special_info_t               special_info_o
);

    logic                                  valid_16, valid_12;
    logic [1:0]                            rd_valid_16, rd_valid_12;
    logic [2*core_pkg::REG_ADDR_WIDTH-1:0] rd_addr_16, rd_addr_12;
    logic [core_pkg::DATA_WIDTH-1:0]       imm_16, imm_12;
    logic                                  wr_valid_16, wr_valid_12;
    logic [core_pkg::REG_ADDR_WIDTH-1:0]   wr_addr_16, wr_addr_12;
    logic [core_pkg::ALU_OP_WIDTH-1:0]     aluop_16, aluop_12;
    logic [core_pkg::ALU_SEL_WIDTH-1:0]    alusel_16, alusel_12;
    core_pkg::special_info_t               info_16, info_12;
    logic                                  load;

    decoder_2ri16 u_dec_2ri16 (
        .instr_i               (head_instr_i),
        .decode_result_valid_o (valid_16),
        .reg_read_valid_o      (rd_valid_16),
        .reg_read_addr_o       (rd_addr_16),
        .imm_o                 (imm_16),
        .reg_write_valid_o     (wr_valid_16),
        .reg_write_addr_o      (wr_addr_16),
        .aluop_o               (aluop_16),
        .alusel_o              (alusel_16),
        .special_info_o        (info_16)
    );

    decoder_2ri12 u_dec_2ri12 (
        .instr_i               (head_instr_i),
        .decode_result_valid_o (valid_12),
        .reg_read_valid_o      (rd_valid_12),
        .reg_read_addr_o       (rd_addr_12),
        .imm_o                 (imm_12),
        .reg_write_valid_o     (wr_valid_12),
        .reg_write_addr_o      (wr_addr_12),
        .aluop_o               (aluop_12),
        .alusel_o              (alusel_12),
        .special_info_o        (info_12)
    );

    // take the head when the output slot is free or leaving this edge
    assign load  = !empty_i && (!out_valid_o || out_ready_i);
    assign pop_o = load;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            out_valid_o <= 1'b0;
        end else if (load) begin
            out_valid_o <= 1'b1;
        end else if (out_ready_i) begin
            out_valid_o <= 1'b0;
        end
    end

    // opcode sets are disjoint and an unmatched decoder drives zeros
    always_ff @(posedge clk) begin
        if (load) begin
            out_pc_o          <= head_pc_i;
            out_instr_o       <= head_instr_i;
            illegal_o         <= !(valid_16 || valid_12);
            reg_read_valid_o  <= rd_valid_16 | rd_valid_12;
            reg_read_addr_o   <= rd_addr_16 | rd_addr_12;
            imm_o             <= imm_16 | imm_12;
            reg_write_valid_o <= wr_valid_16 | wr_valid_12;
            reg_write_addr_o  <= wr_addr_16 | wr_addr_12;
            aluop_o           <= aluop_16 | aluop_12;
            alusel_o          <= alusel_16 | alusel_12;
            special_info_o    <= info_16 | info_12;
        end
    end

    a_hold_when_stalled : assert property (
        @(posedge clk) disable iff (!rst_n_i)
        out_valid_o && !out_ready_i |=> out_valid_o
            && $stable({out_pc_o, out_instr_o, illegal_o, reg_read_valid_o, reg_read_addr_o})
            && $stable({imm_o, reg_write_valid_o, reg_write_addr_o, aluop_o, alusel_o})
            && $stable(special_info_o)
    );

endmodule

// File: decoder_2ri12.sv
// 2RI12 layout is {opcode[10], imm12, rj, rd}, immediate alu group
module decoder_2ri12 (
    input  logic [core_pkg::INSTR_WIDTH-1:0]      instr_i,
    output logic                                  decode_result_valid_o,
    output logic [1:0]                            reg_read_valid_o,
    output logic [2*core_pkg::REG_ADDR_WIDTH-1:0] reg_read_addr_o,
    output logic [core_pkg::DATA_WIDTH-1:0]       imm_o,
    output logic                                  reg_write_valid_o,
    output logic [core_pkg::REG_ADDR_WIDTH-1:0]   reg_write_addr_o,
    output logic [core_pkg::ALU_OP_WIDTH-1:0]     aluop_o,
    output logic [core_pkg::ALU_SEL_WIDTH-1:0]    alusel_o,
    output core_pkg::special_info_t               special_info_o
);

    logic [core_pkg::REG_ADDR_WIDTH-1:0] rd;
    logic [core_pkg::REG_ADDR_WIDTH-1:0] rj;
    logic [11:0]                         imm12;

    assign rd    = instr_i[4:0];
    assign rj    = instr_i[9:5];
    assign imm12 = instr_i[21:10];

    always_comb begin
        decode_result_valid_o      = 1'b1;
        reg_read_valid_o           = 2'b01;
        reg_read_addr_o            = {{core_pkg::REG_ADDR_WIDTH{1'b0}}, rj};
        reg_write_valid_o          = 1'b1;
        reg_write_addr_o           = rd;
        // arithmetic ops sign extend
        imm_o                      = {{20{imm12[11]}}, imm12};
        aluop_o                    = '0;
        alusel_o                   = core_pkg::EXE_RES_ARITH;
        special_info_o.is_branch   = 1'b0;
        special_info_o.branch_type = core_pkg::BRANCH_TYPE_NONE;
        case (instr_i[31:22])
            core_pkg::EXE_ADDI_W: aluop_o = core_pkg::EXE_ADDI_W_OP;
            core_pkg::EXE_SLTI:   aluop_o = core_pkg::EXE_SLTI_OP;
            core_pkg::EXE_SLTUI:  aluop_o = core_pkg::EXE_SLTUI_OP;
            core_pkg::EXE_ANDI, core_pkg::EXE_ORI, core_pkg::EXE_XORI: begin
                // logic ops zero extend
                imm_o    = {20'b0, imm12};
                alusel_o = core_pkg::EXE_RES_LOGIC;
                aluop_o  = (instr_i[31:22] == core_pkg::EXE_ANDI) ? core_pkg::EXE_ANDI_OP :
                           (instr_i[31:22] == core_pkg::EXE_ORI)  ? core_pkg::EXE_ORI_OP  :
                                                                    core_pkg::EXE_XORI_OP;
            end
            default: begin
                decode_result_valid_o = 1'b0;
                reg_read_valid_o      = 2'b00;
                reg_read_addr_o       = '0;
                reg_write_valid_o     = 1'b0;
                reg_write_addr_o      = '0;
                imm_o                 = '0;
                alusel_o              = core_pkg::EXE_RES_NOP;
            end
        endcase
    end

endmodule

// File: decoder_2ri16.sv
// 2RI16 layout is {opcode[6], imm16, rj, rd}, the branch group
module decoder_2ri16 (
    input  logic [core_pkg::INSTR_WIDTH-1:0]      instr_i,
    output logic                                  decode_result_valid_o,
    output logic [1:0]                            reg_read_valid_o,
    output logic [2*core_pkg::REG_ADDR_WIDTH-1:0] reg_read_addr_o,
    output logic [core_pkg::DATA_WIDTH-1:0]       imm_o,
    output logic                                  reg_write_valid_o,
    output logic [core_pkg::REG_ADDR_WIDTH-1:0]   reg_write_addr_o,
    output logic [core_pkg::ALU_OP_WIDTH-1:0]     aluop_o,
    output logic [core_pkg::ALU_SEL_WIDTH-1:0]    alusel_o,
    output core_pkg::special_info_t               special_info_o
);

    logic [core_pkg::REG_ADDR_WIDTH-1:0] rd;
    logic [core_pkg::REG_ADDR_WIDTH-1:0] rj;
    logic [15:0]                         imm16;

    assign rd    = instr_i[4:0];
    assign rj    = instr_i[9:5];
    assign imm16 = instr_i[25:10];

    always_comb begin
        // conditional branch is the common case
        decode_result_valid_o      = 1'b1;
        reg_read_valid_o           = 2'b11;
        reg_read_addr_o            = {rd, rj};
        imm_o                      = {{14{imm16[15]}}, imm16, 2'b00};
        reg_write_valid_o          = 1'b0;
        reg_write_addr_o           = '0;
        aluop_o                    = '0;
        alusel_o                   = core_pkg::EXE_RES_JUMP;
        special_info_o.is_branch   = 1'b1;
        special_info_o.branch_type = core_pkg::BRANCH_TYPE_COND;
        case (instr_i[31:26])
            core_pkg::EXE_JIRL: begin
                aluop_o           = core_pkg::EXE_JIRL_OP;
                reg_read_valid_o  = 2'b01;
                reg_read_addr_o   = {{core_pkg::REG_ADDR_WIDTH{1'b0}}, rj};
                reg_write_valid_o = 1'b1;
                reg_write_addr_o  = rd;
                // jump through r1 is treated as a return
                special_info_o.branch_type = (rj == 5'd1) ? core_pkg::BRANCH_TYPE_RET
                                                          : core_pkg::BRANCH_TYPE_UNCOND;
            end
            core_pkg::EXE_BEQ:  aluop_o = core_pkg::EXE_BEQ_OP;
            core_pkg::EXE_BNE:  aluop_o = core_pkg::EXE_BNE_OP;
            core_pkg::EXE_BLT:  aluop_o = core_pkg::EXE_BLT_OP;
            core_pkg::EXE_BGE:  aluop_o = core_pkg::EXE_BGE_OP;
            core_pkg::EXE_BLTU: aluop_o = core_pkg::EXE_BLTU_OP;
            core_pkg::EXE_BGEU: aluop_o = core_pkg::EXE_BGEU_OP;
            default: begin
                // not ours, everything zero so the merge can OR
                decode_result_valid_o = 1'b0;
                reg_read_valid_o      = 2'b00;
                reg_read_addr_o       = '0;
                imm_o                 = '0;
                alusel_o              = core_pkg::EXE_RES_NOP;
                special_info_o        = '0;
            end
        endcase
    end

endmodule

// File: inst_buffer.sv
module inst_buffer (
    input  logic                             clk,
    input  logic                             rst_n_i,
    input  logic                             push_i,
    input  logic [core_pkg::DATA_WIDTH-1:0]  push_pc_i,
    input  logic [core_pkg::INSTR_WIDTH-1:0] push_instr_i,
    input  logic                             pop_i,
    output logic [core_pkg::DATA_WIDTH-1:0]  head_pc_o,
    output logic [core_pkg::INSTR_WIDTH-1:0] head_instr_o,
    output logic                             full_o,
    output logic                             empty_o
);

    logic [core_pkg::DATA_WIDTH-1:0]  pc_mem    [core_pkg::IBUF_DEPTH];
    logic [core_pkg::INSTR_WIDTH-1:0] instr_mem [core_pkg::IBUF_DEPTH];

    // depth is a power of two so the pointers wrap by themselves
    logic [core_pkg::IBUF_PTR_WIDTH-1:0] wr_ptr_q;
    logic [core_pkg::IBUF_PTR_WIDTH-1:0] rd_ptr_q;
    logic [core_pkg::IBUF_PTR_WIDTH:0]   count_q;

    always_ff @(posedge clk) begin
        if (push_i) begin
            pc_mem[wr_ptr_q]    <= push_pc_i;
            instr_mem[wr_ptr_q] <= push_instr_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop_i) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push_i, pop_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // no bypass, a new word shows up one edge after its push
    assign head_pc_o    = pc_mem[rd_ptr_q];
    assign head_instr_o = instr_mem[rd_ptr_q];
    assign full_o       = (count_q == core_pkg::IBUF_DEPTH);
    assign empty_o      = (count_q == '0);

    a_no_overflow : assert property (
        @(posedge clk) disable iff (!rst_n_i) push_i |-> !full_o
    );

    a_no_underflow : assert property (
        @(posedge clk) disable iff (!rst_n_i) pop_i |-> !empty_o
    );

endmodule

// File: inst_fetch.sv
module inst_fetch (
    input  logic                             clk,
    input  logic                             rst_n_i,
    input  logic                             buffer_full_i,
    input  logic                             wb_ack_i,
    input  logic [core_pkg::DATA_WIDTH-1:0]  wb_dat_i,
    output logic                             wb_cyc_o,
    output logic                             wb_stb_o,
    output logic                             wb_we_o,
    output logic [3:0]                       wb_sel_o,
    output logic [core_pkg::DATA_WIDTH-1:0]  wb_adr_o,
    output logic                             push_o,
    output logic [core_pkg::DATA_WIDTH-1:0]  push_pc_o,
    output logic [core_pkg::INSTR_WIDTH-1:0] push_instr_o
);

    logic [core_pkg::DATA_WIDTH-1:0] pc_q;
    // high while a read is waiting for its ack
    logic                            busy_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            busy_q <= 1'b0;
            pc_q   <= core_pkg::RESET_PC;
        end else if (busy_q) begin
            if (wb_ack_i) begin
                busy_q <= 1'b0;
                pc_q   <= pc_q + 32'd4;
            end
        end else if (!buffer_full_i) begin
            // only one word is in flight so the push always finds room
            busy_q <= 1'b1;
        end
    end

    assign wb_cyc_o = busy_q;
    assign wb_stb_o = busy_q;
    assign wb_we_o  = 1'b0;
    assign wb_sel_o = 4'hf;
    assign wb_adr_o = pc_q;

    // word goes to the queue in the ack cycle
    assign push_o       = busy_q & wb_ack_i;
    assign push_pc_o    = pc_q;
    assign push_instr_o = wb_dat_i;

    // request is held until the slave answers
    a_adr_held : assert property (
        @(posedge clk) disable iff (!rst_n_i)
        wb_stb_o && !wb_ack_i |=> wb_stb_o && $stable(wb_adr_o)
    );

endmodule

// File: core_pkg.sv
package core_pkg;

    // datapath widths
    localparam int INSTR_WIDTH    = 32;
    localparam int DATA_WIDTH     = 32;
    localparam int GPR_NUM        = 32;
    localparam int REG_ADDR_WIDTH = $clog2(GPR_NUM);

    // fetch start address and instruction queue size
    localparam logic [DATA_WIDTH-1:0] RESET_PC = 32'h1c00_0000;
    localparam int IBUF_DEPTH     = 4;
    localparam int IBUF_PTR_WIDTH = $clog2(IBUF_DEPTH);

    localparam int ALU_OP_WIDTH  = 8;
    localparam int ALU_SEL_WIDTH = 3;

    // 2RI16 opcodes in instr[31:26]
    localparam logic [5:0] EXE_JIRL = 6'h13;
    localparam logic [5:0] EXE_BEQ  = 6'h16;
    localparam logic [5:0] EXE_BNE  = 6'h17;
    localparam logic [5:0] EXE_BLT  = 6'h18;
    localparam logic [5:0] EXE_BGE  = 6'h19;
    localparam logic [5:0] EXE_BLTU = 6'h1a;
    localparam logic [5:0] EXE_BGEU = 6'h1b;

    // 2RI12 opcodes in instr[31:22]
    localparam logic [9:0] EXE_SLTI   = 10'h008;
    localparam logic [9:0] EXE_SLTUI  = 10'h009;
    localparam logic [9:0] EXE_ADDI_W = 10'h00a;
    localparam logic [9:0] EXE_ANDI   = 10'h00d;
    localparam logic [9:0] EXE_ORI    = 10'h00e;
    localparam logic [9:0] EXE_XORI   = 10'h00f;

    // one alu op per instruction
    localparam logic [ALU_OP_WIDTH-1:0] EXE_JIRL_OP   = 8'h01;
    localparam logic [ALU_OP_WIDTH-1:0] EXE_BEQ_OP    = 8'h02;
    localparam logic [ALU_OP_WIDTH-1:0] EXE_BNE_OP    = 8'h03;
    localparam logic [ALU_OP_WIDTH-1:0] EXE_BLT_OP    = 8'h04;
    localparam logic [ALU_OP_WIDTH-1:0] EXE_BGE_OP    = 8'h05;
    localparam logic [ALU_OP_WIDTH-1:0] EXE_BLTU_OP   = 8'h06;
    localparam logic [ALU_OP_WIDTH-1:0] EXE_BGEU_OP   = 8'h07;
    localparam logic [ALU_OP_WIDTH-1:0] EXE_ADDI_W_OP = 8'h08;
    localparam logic [ALU_OP_WIDTH-1:0] EXE_SLTI_OP   = 8'h09;
    localparam logic [ALU_OP_WIDTH-1:0] EXE_SLTUI_OP  = 8'h0a;
    localparam logic [ALU_OP_WIDTH-1:0] EXE_ANDI_OP   = 8'h0b;
    localparam logic [ALU_OP_WIDTH-1:0] EXE_ORI_OP    = 8'h0c;
    localparam logic [ALU_OP_WIDTH-1:0] EXE_XORI_OP   = 8'h0d;

    // result select
    localparam logic [ALU_SEL_WIDTH-1:0] EXE_RES_NOP   = 3'd0;
    localparam logic [ALU_SEL_WIDTH-1:0] EXE_RES_ARITH = 3'd1;
    localparam logic [ALU_SEL_WIDTH-1:0] EXE_RES_LOGIC = 3'd2;
    localparam logic [ALU_SEL_WIDTH-1:0] EXE_RES_JUMP  = 3'd3;

    localparam logic [1:0] BRANCH_TYPE_NONE   = 2'd0;
    localparam logic [1:0] BRANCH_TYPE_COND   = 2'd1;
    localparam logic [1:0] BRANCH_TYPE_UNCOND = 2'd2;
    localparam logic [1:0] BRANCH_TYPE_RET    = 2'd3;

    typedef struct packed {
        logic       is_branch;
        logic [1:0] branch_type;
    } special_info_t;

endpackage
